// File: Makefile
# Verilator build and regression run
TOP := tb_branch_pred
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the regression and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "test: FAIL"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || { echo "test: FAIL, run ended early"; exit 1; }
	@echo "test: PASS"

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/bp_history.sv
`timescale 1ns/1ps

// global history and gshare pattern table
// lookups are combinational, resolution updates land on the next edge
module bp_history import bp_pkg::*; (
  input logic clk_in,
  input logic rst_N_in,
  bp_pht_if.responder pht,
  input logic res_valid,
  input logic res_taken,
  input addr_t res_pc
);

  ghr_t ghr;                 // newest outcome in bit 0
  ctr_t ctr_tbl [PHT_SIZE];  // 2-bit counters
  pht_idx_t upd_idx;
  ctr_t upd_ctr;

  // one lookup per slot, sees the value before any same-cycle update
  for (genvar s = 0; s < SLOTS; s++) begin : g_lookup
    pht_idx_t look_idx;

    assign look_idx = {ghr, pht.lookup_pc[s][PHT_N+1:2]};
    assign pht.ctr[s] = ctr_tbl[look_idx];
  end

  assign upd_idx = {ghr, res_pc[PHT_N+1:2]}; // old history selects the entry
  assign upd_ctr = ctr_tbl[upd_idx];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr <= '0;
      for (int i = 0; i < PHT_SIZE; i++) begin
        ctr_tbl[i] <= '0; // strongly not taken
      end
    end else if (res_valid) begin
      ghr <= {ghr[GHR_K-2:0], res_taken}; // shift in the outcome
      if (res_taken) begin
        if (upd_ctr != CTR_MAX) begin
          ctr_tbl[upd_idx] <= upd_ctr + 1'b1;
        end
      end else begin
        if (upd_ctr != '0) begin // saturate at zero
          ctr_tbl[upd_idx] <= upd_ctr - 1'b1;
        end
      end
    end
  end

endmodule

// File: hdl/bp_if.sv
`timescale 1ns/1ps

// pre-decoded bundle, predecode -> predict
interface bp_decode_if import bp_pkg::*; ();

  logic valid;          // bundle present this cycle
  kind_vec_t kind;      // class per slot
  slot_mask_t link;     // bl per slot
  addr_vec_t slot_pc;   // address of each slot
  addr_vec_t target;    // absolute target, zero for ret and non-branch

  modport source (
    output valid,
    output kind,
    output link,
    output slot_pc,
    output target
  );

  modport sink (
    input valid,
    input kind,
    input link,
    input slot_pc,
    input target
  );

endinterface

// counter lookup, predict -> history
interface bp_pht_if import bp_pkg::*; ();

  addr_vec_t lookup_pc; // pc of each slot
  ctr_vec_t ctr;        // counter seen at {ghr, pc[5:2]}

  modport requester (
    output lookup_pc,
    input ctr
  );

  modport responder (
    input lookup_pc,
    output ctr
  );

endinterface

// File: hdl/bp_pkg.sv
package bp_pkg;

  // bundle shape, fixed at two words per fetch
  localparam int SLOTS = 2;
  localparam int INSTR_W = 32;
  localparam int SLOT_BYTES = INSTR_W / 8; // byte stride between slots

  typedef logic [63:0] addr_t;              // instruction address
  typedef logic [INSTR_W-1:0] instr_t;      // one instruction word
  typedef logic [SLOTS*INSTR_W-1:0] bundle_t; // slot 0 in the low word
  typedef logic [SLOTS-1:0] slot_mask_t;    // one bit per slot

  // branch classes
  typedef logic [1:0] brk_kind_t;
  localparam brk_kind_t BRK_NONE = 2'd0;
  localparam brk_kind_t BRK_B = 2'd1;
  localparam brk_kind_t BRK_BL = 2'd1;      // shares the b class, link bit tells them apart
  localparam brk_kind_t BRK_RET = 2'd2;
  localparam brk_kind_t BRK_COND = 2'd3;

  // opcode match values
  localparam logic [5:0] OPC_B = 6'b000101;       // bits 31:26
  localparam logic [5:0] OPC_BL = 6'b100101;      // bits 31:26
  localparam logic [10:0] OPC_RET = 11'b11010110010; // bits 31:21
  localparam logic [7:0] OPC_BCOND = 8'b01010100; // bits 31:24

  // gshare geometry
  localparam int GHR_K = 4;                 // history bits
  localparam int PHT_N = 4;                 // pc bits 5:2
  localparam int PHT_SIZE = 1 << (GHR_K + PHT_N);
  typedef logic [GHR_K-1:0] ghr_t;
  typedef logic [GHR_K+PHT_N-1:0] pht_idx_t; // {history, pc bits}

  // 2-bit saturating counter
  typedef logic [1:0] ctr_t;
  localparam ctr_t CTR_MAX = 2'd3;
  localparam ctr_t CTR_TAKEN = 2'd2;        // weakly taken and up

  // return stack
  localparam int RAS_DEPTH = 8;
  typedef logic [$clog2(RAS_DEPTH)-1:0] ras_ptr_t;
  typedef logic [$clog2(RAS_DEPTH+1)-1:0] ras_cnt_t; // 0 .. RAS_DEPTH

  // per-slot vectors
  typedef brk_kind_t [SLOTS-1:0] kind_vec_t;
  typedef addr_t [SLOTS-1:0] addr_vec_t;
  typedef ctr_t [SLOTS-1:0] ctr_vec_t;

endpackage

// File: hdl/bp_predecode.sv
`timescale 1ns/1ps

// splits a fetch bundle into slots and classifies each word
// purely combinational, no prediction happens here
module bp_predecode import bp_pkg::*; (
  input logic fetch_valid,
  input addr_t fetch_pc,
  input bundle_t fetch_bundle,
  bp_decode_if.source dec
);

  assign dec.valid = fetch_valid; // passes straight through

  for (genvar s = 0; s < SLOTS; s++) begin : g_slot
    instr_t word;
    logic is_b;
    logic is_bl;
    logic is_ret;
    logic is_cond;
    addr_t pc;
    addr_t off_imm26; // b / bl offset in bytes
    addr_t off_imm19; // b.cond offset in bytes
    addr_t off_sel;

    assign word = fetch_bundle[s*INSTR_W +: INSTR_W];
    assign pc = fetch_pc + addr_t'(SLOT_BYTES * s); // slot 1 sits 4 bytes up

    // opcode matches, the four encodings never overlap
    assign is_b = word[31:26] == OPC_B;
    assign is_bl = word[31:26] == OPC_BL;
    assign is_ret = word[31:21] == OPC_RET;
    assign is_cond = word[31:24] == OPC_BCOND;

    // sign extend and scale by four
    assign off_imm26 = {{36{word[25]}}, word[25:0], 2'b00};
    assign off_imm19 = {{43{word[23]}}, word[23:5], 2'b00};
    assign off_sel = is_cond ? off_imm19 : off_imm26;

    assign dec.slot_pc[s] = pc;
    assign dec.link[s] = is_bl;

    // ret is resolved from the stack later, so it gets no target here
    assign dec.target[s] = (is_b || is_bl || is_cond) ? pc + off_sel : '0;

    assign dec.kind[s] = is_ret  ? BRK_RET  :
                         is_bl   ? BRK_BL   :
                         is_b    ? BRK_B    :
                         is_cond ? BRK_COND :
                                   BRK_NONE;
  end

endmodule

// File: hdl/bp_predict.sv
`timescale 1ns/1ps

// slot scan, next fetch address and registered outputs
// the first redirecting slot ends the bundle
module bp_predict import bp_pkg::*; (
  input logic clk_in,
  input logic rst_N_in,
  bp_decode_if.sink dec,
  bp_pht_if.requester pht,
  input logic res_mispredict,
  input addr_t res_target,
  output logic pred_valid,
  output addr_t pred_pc,
  output slot_mask_t pred_branch_mask,
  output slot_mask_t pred_taken_mask
);

  addr_t ras_top;
  logic ras_push;
  logic ras_pop;
  addr_t ras_push_addr;

  addr_t next_pc;         // scan result
  slot_mask_t br_mask;
  slot_mask_t tk_mask;
  logic want_push;
  logic want_pop;
  logic scan_done;
  logic fetch_ok;         // bundle survives the mispredict check

  assign pht.lookup_pc = dec.slot_pc; // counters come back this cycle

  always_comb begin
    next_pc = dec.slot_pc[0] + addr_t'(SLOTS * SLOT_BYTES); // fall through
    br_mask = '0;
    tk_mask = '0;
    want_push = 1'b0;
    want_pop = 1'b0;
    ras_push_addr = '0;
    scan_done = 1'b0;
    for (int s = 0; s < SLOTS; s++) begin
      if (!scan_done && dec.kind[s] != BRK_NONE) begin
        br_mask[s] = 1'b1; // scanned branch
        case (dec.kind[s])
          BRK_B: begin // b and bl
            scan_done = 1'b1;
            tk_mask[s] = 1'b1;
            next_pc = dec.target[s];
            if (dec.link[s]) begin
              want_push = 1'b1;
              ras_push_addr = dec.slot_pc[s] + addr_t'(SLOT_BYTES); // return past the bl
            end
          end
          BRK_RET: begin
            scan_done = 1'b1;
            tk_mask[s] = 1'b1;
            next_pc = ras_top;  // already zero on an empty stack
            want_pop = 1'b1;
          end
          BRK_COND: begin
            if (pht.ctr[s] >= CTR_TAKEN) begin
              scan_done = 1'b1;
              tk_mask[s] = 1'b1;
              next_pc = dec.target[s];
            end // not taken keeps scanning
          end
          default: ;
        endcase
      end
    end
  end

  // mispredict wins, a fetch in the same cycle is dropped
  assign fetch_ok = dec.valid && !res_mispredict;
  assign ras_push = fetch_ok && want_push;
  assign ras_pop = fetch_ok && want_pop;

  bp_return_stack u_ras (
    .clk_in(clk_in),
    .rst_N_in(rst_N_in),
    .push(ras_push),
    .pop(ras_pop),
    .push_addr(ras_push_addr),
    .top(ras_top),
    .empty()
  );

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      pred_valid <= 1'b0;
      pred_pc <= '0;
      pred_branch_mask <= '0;
      pred_taken_mask <= '0;
    end else begin
      pred_valid <= res_mispredict || dec.valid; // one cycle strobe
      if (res_mispredict) begin
        pred_pc <= res_target;
        pred_branch_mask <= '0;
        pred_taken_mask <= '0;
      end else if (dec.valid) begin
        pred_pc <= next_pc;
        pred_branch_mask <= br_mask;
        // a ret on an empty stack still redirects, to zero
        pred_taken_mask <= tk_mask;
      end // idle keeps the last values
    end
  end

endmodule

// File: hdl/bp_return_stack.sv
`timescale 1ns/1ps

// circular return address stack
// top_ptr points at the newest entry, count saturates at RAS_DEPTH
module bp_return_stack import bp_pkg::*; (
  input logic clk_in,
  input logic rst_N_in,
  input logic push,
  input logic pop,
  input addr_t push_addr,
  output addr_t top,
  output logic empty
);

  addr_t mem [RAS_DEPTH];
  ras_ptr_t top_ptr;
  ras_ptr_t push_ptr;
  ras_cnt_t count;

  assign push_ptr = top_ptr + 1'b1; // wraps, so a full push lands on the oldest
  assign empty = count == '0;
  assign top = empty ? '0 : mem[top_ptr]; // zero when nothing is stored

  // pointer and occupancy
  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      top_ptr <= '0;
      count <= '0;
    end else if (push) begin
      top_ptr <= push_ptr;
      if (count != ras_cnt_t'(RAS_DEPTH)) begin
        count <= count + 1'b1;
      end
    end else if (pop && !empty) begin // pop on empty is ignored
      top_ptr <= top_ptr - 1'b1;
      count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[push_ptr] <= push_addr;
    end
  end

endmodule

// File: hdl/branch_pred_top.sv
`timescale 1ns/1ps

// branch prediction front end
// predecode -> predict, with history serving counters to predict
module branch_pred_top import bp_pkg::*; (
  input logic clk_in,
  input logic rst_N_in,
  input logic fetch_valid,
  input addr_t fetch_pc,
  input bundle_t fetch_bundle,
  input logic res_valid,
  input logic res_taken,
  input addr_t res_pc,
  input logic res_mispredict,
  input addr_t res_target,
  output logic pred_valid,
  output addr_t pred_pc,
  output slot_mask_t pred_branch_mask,
  output slot_mask_t pred_taken_mask
);

  bp_decode_if dec_if ();
  bp_pht_if pht_if ();

  bp_predecode u_predecode (
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .fetch_bundle(fetch_bundle),
    .dec(dec_if.source)
  );

  bp_predict u_predict (
    .clk_in(clk_in),
    .rst_N_in(rst_N_in),
    .dec(dec_if.sink),
    .pht(pht_if.requester),
    .res_mispredict(res_mispredict),
    .res_target(res_target),
    .pred_valid(pred_valid),
    .pred_pc(pred_pc),
    .pred_branch_mask(pred_branch_mask),
    .pred_taken_mask(pred_taken_mask)
  );

  // resolution writeback
  bp_history u_history (
    .clk_in(clk_in),
    .rst_N_in(rst_N_in),
    .pht(pht_if.responder),
    .res_valid(res_valid),
    .res_taken(res_taken),
    .res_pc(res_pc)
  );

endmodule

// File: project.f
hdl/bp_pkg.sv
hdl/bp_if.sv
hdl/bp_predecode.sv
hdl/bp_return_stack.sv
hdl/bp_history.sv
hdl/bp_predict.sv
hdl/branch_pred_top.sv
tests/bp_chk.sv
tests/tb_branch_pred.sv

// File: tests/bp_chk.sv
`timescale 1ns/1ps

// output checks on the predict stage, bound into bp_predict
module bp_chk import bp_pkg::*; (
  input logic clk_in,
  input logic rst_N_in,
  input logic pred_valid,
  input slot_mask_t pred_branch_mask,
  input slot_mask_t pred_taken_mask
);

  // nothing comes out of the first cycle after reset
  a_idle_after_reset: assert property (
    @(posedge clk_in) rst_N_in |=> !pred_valid
  ) else $error("pred_valid high in the cycle after reset");

  // at most one slot redirects
  a_taken_onehot: assert property (
    @(posedge clk_in) disable iff (rst_N_in) $onehot0(pred_taken_mask)
  ) else $error("pred_taken_mask has more than one bit set");

  // a taken slot is always a scanned branch
  a_taken_subset: assert property (
    @(posedge clk_in) disable iff (rst_N_in)
      (pred_taken_mask & ~pred_branch_mask) == '0
  ) else $error("pred_taken_mask marks a slot that is not a branch");

endmodule

// File: tests/tb_branch_pred.sv
`timescale 1ns/1ps

// testbench for the branch prediction front end
module tb_branch_pred import bp_pkg::*; ();

  typedef struct packed {
    logic valid;
    addr_t pc;
    slot_mask_t br;
    slot_mask_t tk;
  } exp_t;

  localparam int RAND_LEN = 300;
  localparam int CYCLE_LIMIT = 5 * 6 + 200 + RAND_LEN + 100; // resets, directed, random, margin
  localparam instr_t I_NOP = 32'hd503201f;
  localparam instr_t I_RET = 32'hd65f03c0;

  logic clk_in = 1'b0;
  logic rst_N_in;
  logic fetch_valid;
  addr_t fetch_pc;
  bundle_t fetch_bundle;
  logic res_valid;
  logic res_taken;
  addr_t res_pc;
  logic res_mispredict;
  addr_t res_target;
  logic pred_valid;
  addr_t pred_pc;
  slot_mask_t pred_branch_mask;
  slot_mask_t pred_taken_mask;

  // model state
  ghr_t ref_ghr;
  ctr_t ref_pht [256];
  addr_t ref_ras [RAS_DEPTH];
  int ref_top;                 // newest entry
  int ref_cnt;
  exp_t ref_last;              // outputs hold these when idle

  exp_t exp_q [$];             // one entry per driven cycle
  exp_t cmp_e;
  logic [31:0] rnd;
  integer seed = 32'heaad;
  int cycles = 0;
  int errors = 0;
  int test_base = 0;
  int tests_run = 0;
  int tests_failed = 0;

  always #20 clk_in = ~clk_in;

  branch_pred_top u_dut (.*);

  bind bp_predict bp_chk u_chk (.*);

  function automatic instr_t enc_b(input logic [25:0] imm);
    return {6'b000101, imm};
  endfunction

  function automatic instr_t enc_bl(input logic [25:0] imm);
    return {6'b100101, imm};
  endfunction

  function automatic instr_t enc_bcond(input logic [18:0] imm);
    return {8'h54, imm, 5'h0}; // cond eq
  endfunction

  function automatic instr_t rand_word();
    int k;
    k = int'($unsigned($random(seed)) % 32'd5);
    case (k)
      1: return enc_b(26'($random(seed)));
      2: return enc_bl(26'($random(seed)));
      3: return I_RET;
      4: return enc_bcond(19'($random(seed)));
      default: return I_NOP;
    endcase
  endfunction

  function automatic void model_reset();
    ref_ghr = '0;
    for (int i = 0; i < 256; i++) begin
      ref_pht[i] = '0;
    end
    ref_top = 0;
    ref_cnt = 0;
    ref_last = '0;
  endfunction

  // expected outputs for one cycle of inputs, then the state updates of that cycle
  function automatic exp_t bp_ref(input logic fv, input addr_t pc, input bundle_t bun,
                                  input logic rv, input logic rt, input addr_t rpc,
                                  input logic mp, input addr_t mt);
    exp_t e;
    instr_t w;
    addr_t spc;
    logic done;
    int idx;
    e = ref_last;
    e.valid = 1'b0;
    if (mp) begin // fetch in the same cycle is dropped
      e = {1'b1, mt, 2'b00, 2'b00};
    end else if (fv) begin
      e = {1'b1, pc + 64'd8, 2'b00, 2'b00}; // fall through unless a slot redirects
      done = 1'b0;
      for (int s = 0; s < SLOTS; s++) begin
        w = bun[32*s +: 32];
        spc = pc + addr_t'(4 * s);
        if (!done && (w[31:26] == 6'b000101 || w[31:26] == 6'b100101)) begin
          e.br[s] = 1'b1;
          e.tk[s] = 1'b1;
          done = 1'b1;
          e.pc = spc + addr_t'(longint'($signed(w[25:0])) * 4);
          if (w[31]) begin // bl, push the return address
            ref_top = (ref_top + 1) % RAS_DEPTH;
            ref_ras[ref_top] = spc + 64'd4;
            ref_cnt = (ref_cnt < RAS_DEPTH) ? ref_cnt + 1 : ref_cnt;
          end
        end else if (!done && w[31:21] == 11'b11010110010) begin
          e.br[s] = 1'b1;
          e.tk[s] = 1'b1;
          done = 1'b1;
          e.pc = (ref_cnt == 0) ? '0 : ref_ras[ref_top]; // empty stack gives zero
          if (ref_cnt > 0) begin
            ref_top = (ref_top + RAS_DEPTH - 1) % RAS_DEPTH;
            ref_cnt--;
          end
        end else if (!done && w[31:24] == 8'h54) begin
          e.br[s] = 1'b1;
          idx = int'({ref_ghr, spc[5:2]});
          if (ref_pht[idx] >= 2'd2) begin
            e.tk[s] = 1'b1;
            done = 1'b1;
            e.pc = spc + addr_t'(longint'($signed(w[23:5])) * 4);
          end
        end
      end
    end
    if (e.valid) begin
      ref_last = e;
    end
    if (rv) begin // lookups above used the old counters and history
      idx = int'({ref_ghr, rpc[5:2]});
      if (rt && ref_pht[idx] != 2'd3) begin
        ref_pht[idx] = ref_pht[idx] + 2'd1;
      end else if (!rt && ref_pht[idx] != 2'd0) begin
        ref_pht[idx] = ref_pht[idx] - 2'd1;
      end
      ref_ghr = {ref_ghr[GHR_K-2:0], rt};
    end
    return e;
  endfunction

  task automatic check_addr(input string name, input addr_t got, input addr_t want);
    if (got !== want) begin
      $display("FAILED %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_mask(input string name, input slot_mask_t got, input slot_mask_t want);
    if (got !== want) begin
      $display("FAILED %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic drive(input logic fv, input addr_t pc, input bundle_t bun, input logic rv,
                       input logic rt, input addr_t rpc, input logic mp, input addr_t mt);
    @(posedge clk_in);
    fetch_valid <= fv;
    fetch_pc <= pc;
    fetch_bundle <= bun;
    res_valid <= rv;
    res_taken <= rt;
    res_pc <= rpc;
    res_mispredict <= mp;
    res_target <= mt;
    exp_q.push_back(bp_ref(fv, pc, bun, rv, rt, rpc, mp, mt)); // due one cycle later
  endtask

  task automatic fetch(input addr_t pc, input instr_t w0, input instr_t w1);
    drive(1'b1, pc, {w1, w0}, 1'b0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic resolve(input addr_t pc, input logic taken);
    drive(1'b0, '0, '0, 1'b1, taken, pc, 1'b0, '0);
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic apply_reset();
    @(posedge clk_in);
    rst_N_in <= 1'b1;
    fetch_valid <= 1'b0;
    res_valid <= 1'b0;
    res_mispredict <= 1'b0;
    repeat (5) @(posedge clk_in);
    rst_N_in <= 1'b0;
    exp_q.delete(); // nothing is due across a reset
    model_reset();
  endtask

  task automatic end_test(input string name);
    idle(2); // lets the last real cycle be compared
    tests_run++;
    if (errors != test_base) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d errors", name, (errors == test_base) ? "ok" : "bad",
             errors - test_base);
    test_base = errors;
  endtask

  // compare, half a cycle after the outputs settle
  always @(negedge clk_in) begin
    if (exp_q.size() == 2) begin
      cmp_e = exp_q.pop_front();
      if (pred_valid !== cmp_e.valid && cmp_e.valid) begin
        $display("pred_valid missing after a fetch or mispredict");
        errors++;
      end else if (pred_valid !== cmp_e.valid) begin
        $display("pred_valid raised in a cycle with no fetch and no mispredict");
        errors++;
      end
      check_addr("pred_pc", pred_pc, cmp_e.pc);
      check_mask("pred_branch_mask", pred_branch_mask, cmp_e.br);
      check_mask("pred_taken_mask", pred_taken_mask, cmp_e.tk);
    end
  end

  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the stimulus did not finish", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    rst_N_in = 1'b1;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_bundle = '0;
    res_valid = 1'b0;
    res_taken = 1'b0;
    res_pc = '0;
    res_mispredict = 1'b0;
    res_target = '0;
    apply_reset();

    fetch(64'h1000, I_NOP, I_NOP);
    fetch(64'h2004, I_NOP, I_NOP);
    fetch(64'hffff_0ff8, I_NOP, I_NOP);
    end_test("no_branch");

    fetch(64'h1000, enc_b(26'd16), enc_bl(26'd4));   // slot 1 left unscanned
    fetch(64'h1000, I_NOP, enc_bl(26'h3fffff8));    // -8 words
    fetch(64'h2000, enc_bl(26'h3fffff0), I_NOP);
    fetch(64'h3000, I_NOP, enc_b(26'h40));
    fetch(64'h3000, enc_b(26'h3ffffff), I_RET);     // ret never reached
    end_test("direct");

    apply_reset();
    fetch(64'h1000, enc_bl(26'd64), I_NOP);         // push 1004
    fetch(64'h1100, I_NOP, I_NOP);
    fetch(64'h1200, I_RET, I_NOP);
    fetch(64'h2000, enc_bl(26'd8), I_NOP);
    fetch(64'h3000, I_NOP, enc_bl(26'd8));          // nested, push 3008
    fetch(64'h4000, I_RET, I_NOP);
    fetch(64'h4000, I_NOP, I_RET);
    fetch(64'h5000, I_RET, I_RET);                  // empty stack, zero
    for (int i = 0; i < 9; i++) begin
      fetch(64'h8000 + addr_t'(i * 64), enc_bl(26'd1), I_NOP); // ninth drops the oldest
    end
    for (int i = 0; i < 9; i++) begin
      fetch(64'h9000, I_RET, I_NOP);
    end
    end_test("return_stack");

    apply_reset();
    fetch(64'h6010, enc_bcond(19'd32), I_NOP);      // counter 0, not taken
    resolve(64'h6010, 1'b1);
    repeat (4) resolve(64'h7000, 1'b0);             // history back to zero
    drive(1'b1, 64'h6010, {I_NOP, enc_bcond(19'd32)}, 1'b1, 1'b1, 64'h6010, 1'b0, '0);
    fetch(64'h6010, enc_bcond(19'd32), I_NOP);      // new history, other entry
    repeat (4) resolve(64'h7000, 1'b0);
    fetch(64'h6010, enc_bcond(19'd32), enc_b(26'd2));
    fetch(64'h6020, enc_bcond(19'd4), enc_b(26'd2));
    end_test("cond");

    fetch(64'ha000, enc_bl(26'd16), I_NOP);         // push a004
    drive(1'b1, 64'hb000, {enc_bl(26'd4), I_NOP}, 1'b0, 1'b0, '0, 1'b1, 64'hc0de_0000);
    drive(1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b1, 64'h1234_5678);
    fetch(64'hc000, I_RET, I_NOP);                  // still a004
    end_test("mispredict");

    for (int i = 0; i < RAND_LEN; i++) begin
      rnd = $random(seed);
      drive(rnd[1:0] != 2'b00, 64'h4000_0000 + addr_t'({rnd[13:4], 2'b00}),
            {rand_word(), rand_word()}, rnd[14], rnd[15],
            64'h4000_0000 + addr_t'({rnd[23:16], 2'b00}), rnd[27:24] == 4'hf,
            addr_t'({rnd[31:28], 8'h00}));
    end
    end_test("random");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
